// File: bench/ifu_cases.txt
// Columns: kind (1 wait, 2 freeze, 3 redirect, 0 end), value, last PC after a wait
// Wait value counts deliveries, freeze value is the minimum cycle count
1 00000004 0000000C
2 00000003 00000000
1 00000003 00000018
3 00000100 00000000
1 00000002 00000104
2 00000005 00000000
3 00000200 00000000
1 00000003 00000208
2 00000001 00000000
1 00000004 00000218
3 00000040 00000000
3 00000080 00000000
1 00000003 00000088
2 00000002 00000000
1 00000002 00000090
3 00001000 00000000
1 00000005 00001010
0 00000000 00000000

// File: bench/instbus_model.sv
`timescale 1ns/1ps

// Instruction bus responder with a random 1 to 4 cycle latency
module instbus_model #(
  parameter ifu_pkg::inst_t DATA_KEY = '0
) (
  input  logic           clk,
  input  logic           rst,

  input  logic           i_req,
  input  ifu_pkg::addr_t i_req_addr,

  output logic           o_ack,
  output ifu_pkg::addr_t o_ack_addr,
  output ifu_pkg::inst_t o_ack_data
);

  initial begin
    ifu_pkg::addr_t addr;
    int             delay;

    o_ack      = 1'b0;
    o_ack_addr = '0;
    o_ack_data = '0;

    forever begin
      @(negedge clk);
      if (!rst && i_req) begin
        addr  = i_req_addr;
        delay = 1 + int'($urandom % 4);
        repeat (delay) @(posedge clk);
        #2;
        o_ack      = 1'b1;
        o_ack_addr = addr;  // Echo of the request address
        o_ack_data = addr ^ DATA_KEY;
        @(posedge clk);
        #2;
        o_ack = 1'b0;
      end
    end
  end

endmodule

// File: bench/tb_riscv_ifu.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module tb_riscv_ifu;

  localparam ifu_pkg::inst_t DATA_KEY  = 32'h5a3c_96e1;  // Responder XOR pattern
  localparam ifu_pkg::addr_t STRIDE    = `IFU_PC_STRIDE;
  localparam ifu_pkg::addr_t RESET_PC  = `IFU_RESET_PC;
  localparam int             MAX_STEPS = 64;

  localparam int STEP_WAIT     = 1;
  localparam int STEP_FREEZE   = 2;
  localparam int STEP_REDIRECT = 3;

  logic           clk;
  logic           rst;
  logic           alu_vld;
  logic           alu_br_miss;
  logic           alu_trap;
  ifu_pkg::addr_t alu_pc_next;
  logic           idu_freeze;
  logic           ifu_vld;
  ifu_pkg::inst_t ifu_inst;
  ifu_pkg::addr_t ifu_inst_pc;
  logic           instbus_req;
  ifu_pkg::addr_t instbus_addr;
  logic           instbus_ack;
  ifu_pkg::addr_t instbus_ack_addr;
  ifu_pkg::inst_t instbus_data;

  // Three words per step: kind, value, last delivered PC for wait steps
  logic [31:0] cases [0:3*MAX_STEPS-1];

  int             errors;
  int             checks;
  int             deliveries;
  int             wd_cycles;
  ifu_pkg::addr_t last_pc;
  ifu_pkg::addr_t exp_pc;     // Next PC decode should see
  ifu_pkg::addr_t exp_fetch;  // Next address the bus should see
  logic           outstanding;
  logic           block_vld;

  riscv_ifu dut_i (
    .clk            (clk),
    .rst            (rst),
    .i_alu_vld      (alu_vld),
    .i_alu_br_miss  (alu_br_miss),
    .i_alu_trap     (alu_trap),
    .i_alu_pc_next  (alu_pc_next),
    .i_idu_freeze   (idu_freeze),
    .o_ifu_vld      (ifu_vld),
    .o_ifu_inst     (ifu_inst),
    .o_ifu_inst_pc  (ifu_inst_pc),
    .o_instbus_req  (instbus_req),
    .o_instbus_addr (instbus_addr),
    .i_instbus_ack  (instbus_ack),
    .i_instbus_addr (instbus_ack_addr),
    .i_instbus_data (instbus_data)
  );

  instbus_model #(.DATA_KEY(DATA_KEY)) bus_i (
    .clk        (clk),
    .rst        (rst),
    .i_req      (instbus_req),
    .i_req_addr (instbus_addr),
    .o_ack      (instbus_ack),
    .o_ack_addr (instbus_ack_addr),
    .o_ack_data (instbus_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_addr(input string name, input ifu_pkg::addr_t exp,
                            input ifu_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_inst(input string name, input ifu_pkg::inst_t exp,
                            input ifu_pkg::inst_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  // Decode and bus side observer, mid cycle
  always @(negedge clk) begin
    if (rst) begin
      check_bit("o_instbus_req", 1'b0, instbus_req);
      check_bit("o_ifu_vld", 1'b0, ifu_vld);
      exp_pc      = RESET_PC;
      exp_fetch   = RESET_PC;
      outstanding = 1'b0;
      block_vld   = 1'b0;
    end else begin
      if (instbus_ack) begin
        outstanding = 1'b0;
      end
      if (instbus_req) begin
        if (outstanding) begin
          report_failure("bus request issued while the previous one had no ack");
        end
        check_addr("o_instbus_addr", exp_fetch, instbus_addr);
        exp_fetch   = exp_fetch + STRIDE;
        outstanding = 1'b1;
      end
      if (block_vld) begin
        check_bit("o_ifu_vld", 1'b0, ifu_vld);  // Cycle after freeze or redirect
      end
      if (ifu_vld) begin
        check_addr("o_ifu_inst_pc", exp_pc, ifu_inst_pc);
        check_inst("o_ifu_inst", exp_pc ^ DATA_KEY, ifu_inst);
        last_pc    = ifu_inst_pc;
        exp_pc     = exp_pc + STRIDE;
        deliveries = deliveries + 1;
      end
      block_vld = idu_freeze;
      if (alu_vld && (alu_br_miss || alu_trap)) begin
        exp_pc    = alu_pc_next;
        exp_fetch = alu_pc_next;
        block_vld = 1'b1;
      end
    end
  end

  task automatic wait_deliveries(input int count, input ifu_pkg::addr_t last_exp);
    int target;
    target = deliveries + count;
    while (deliveries < target) begin
      @(posedge clk);
      #2;
    end
    check_addr("last delivered pc", last_exp, last_pc);
  endtask

  task automatic freeze_decode(input int cycles);
    int len;
    len        = cycles + int'($urandom % 4);
    idu_freeze = 1'b1;
    repeat (len) begin
      @(posedge clk);
      #2;
    end
    idu_freeze = 1'b0;
  endtask

  task automatic redirect_to(input ifu_pkg::addr_t target, input logic use_trap);
    alu_vld     = 1'b1;
    alu_pc_next = target;
    alu_br_miss = !use_trap;
    alu_trap    = use_trap;
    @(posedge clk);
    #2;
    alu_vld     = 1'b0;
    alu_br_miss = 1'b0;
    alu_trap    = 1'b0;
  endtask

  initial begin
    int step;
    int kind;
    int total_deliv;
    int total_freeze;

    void'($urandom(32'h1c8e_ca1f));
    rst          = 1'b1;
    alu_vld      = 1'b0;
    alu_br_miss  = 1'b0;
    alu_trap     = 1'b0;
    alu_pc_next  = '0;
    idu_freeze   = 1'b0;
    errors       = 0;
    checks       = 0;
    deliveries   = 0;
    last_pc      = '0;
    total_deliv  = 0;
    total_freeze = 0;

    for (step = 0; step < 3 * MAX_STEPS; step++) begin
      cases[step] = '0;
    end
    $readmemh("bench/ifu_cases.txt", cases);

    for (step = 0; step < MAX_STEPS; step++) begin
      kind = int'(cases[3*step]);
      if (kind == STEP_WAIT) begin
        total_deliv += int'(cases[3*step+1]);
      end else if (kind == STEP_FREEZE) begin
        total_freeze += int'(cases[3*step+1]) + 3;  // Worst random extension
      end
    end
    wd_cycles = total_deliv * 8 + total_freeze + 200;

    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    for (step = 0; step < MAX_STEPS; step++) begin
      kind = int'(cases[3*step]);
      if (kind == 0) begin
        break;
      end
      case (kind)
        STEP_WAIT:     wait_deliveries(int'(cases[3*step+1]), cases[3*step+2]);
        STEP_FREEZE:   freeze_decode(int'(cases[3*step+1]));
        STEP_REDIRECT: redirect_to(cases[3*step+1], step[0]);
        default:       report_failure("unknown step kind in the case file");
      endcase
    end

    repeat (8) @(posedge clk);
    $display("checks %0d, errors %0d, deliveries %0d", checks, errors, deliveries);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, only %0d words delivered", wd_cycles, deliveries);
    $display("sim failed");
    $finish;
  end

endmodule

// File: hw/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// Machine word, shared by addresses and instructions
`define IFU_XLEN 32

// First fetch address after reset
`define IFU_RESET_PC 32'h0000_0000

// Bytes per sequential fetch
`define IFU_PC_STRIDE 4

`endif

// File: hw/ifu_fetch_ctrl.sv
`timescale 1ns/1ps

module ifu_fetch_ctrl (
  input  logic           clk,
  input  logic           rst,

  input  logic           i_alu_vld,
  input  logic           i_alu_br_miss,
  input  logic           i_alu_trap,

  input  logic           i_idu_freeze,

  input  logic           i_instbus_ack,
  input  ifu_pkg::addr_t i_pc,

  output logic           o_instbus_req,
  output ifu_pkg::addr_t o_instbus_addr,

  output logic           o_advance,
  output logic           o_redirect,
  output logic           o_capture,
  output logic           o_deliver
);

  ifu_pkg::fetch_state_t state;
  ifu_pkg::fetch_state_t state_nxt;

  logic discard;      // Outstanding ack belongs to a flushed path
  logic discard_nxt;

  logic redirect;
  logic issue;        // Register a new bus request this edge
  logic capture;
  logic deliver;

  // Branch miss and trap share one target
  assign redirect = i_alu_vld & (i_alu_br_miss | i_alu_trap);

  always_comb begin
    state_nxt   = state;
    discard_nxt = discard;
    issue       = 1'b0;
    capture     = 1'b0;
    deliver     = 1'b0;

    case (state)
      ifu_pkg::FS_IDLE: begin
        // On redirect wait one cycle so i_pc already holds the target
        if (!redirect) begin
          issue     = 1'b1;
          state_nxt = ifu_pkg::FS_FETCH;
        end
      end

      ifu_pkg::FS_FETCH: begin
        if (redirect) begin
          if (i_instbus_ack) begin
            // Ack lands with the flush so nothing is left in flight
            discard_nxt = 1'b0;
            state_nxt   = ifu_pkg::FS_IDLE;
          end else begin
            discard_nxt = 1'b1;
          end
        end else if (i_instbus_ack) begin
          if (discard) begin
            // Stale word dropped and fetch restarts at the target
            discard_nxt = 1'b0;
            issue       = 1'b1;
          end else if (i_idu_freeze) begin
            capture   = 1'b1;
            state_nxt = ifu_pkg::FS_HOLD;
          end else begin
            capture = 1'b1;
            deliver = 1'b1;
            issue   = 1'b1;  // Back to back with delivery
          end
        end
      end

      ifu_pkg::FS_HOLD: begin
        if (redirect) begin
          state_nxt = ifu_pkg::FS_IDLE;  // Held word is thrown away
        end else if (!i_idu_freeze) begin
          deliver   = 1'b1;
          issue     = 1'b1;
          state_nxt = ifu_pkg::FS_FETCH;
        end
      end

      default: begin
        state_nxt   = ifu_pkg::FS_IDLE;
        discard_nxt = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ifu_pkg::FS_IDLE;
      discard       <= 1'b0;
      o_instbus_req <= 1'b0;
    end else begin
      state         <= state_nxt;
      discard       <= discard_nxt;
      o_instbus_req <= issue;  // One cycle strobe
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      o_instbus_addr <= i_pc;
    end
  end

  // PC steps past every word that goes out on the bus
  assign o_advance  = issue;
  assign o_redirect = redirect;
  assign o_capture  = capture;
  assign o_deliver  = deliver;

  // The responder may only answer the single outstanding request
  a_ack_only_in_fetch : assert property (
    @(posedge clk) disable iff (rst)
    i_instbus_ack |-> (state == ifu_pkg::FS_FETCH)
  ) else $error("ifu_fetch_ctrl: bus ack with no request outstanding");

  // The bus answers one or more cycles after the request
  a_no_ack_with_req : assert property (
    @(posedge clk) disable iff (rst)
    o_instbus_req |-> !i_instbus_ack
  ) else $error("ifu_fetch_ctrl: bus ack in the same cycle as its request");

endmodule

// File: hw/ifu_inst_buffer.sv
`timescale 1ns/1ps

module ifu_inst_buffer (
  input  logic           clk,
  input  logic           rst,

  input  logic           i_capture,
  input  logic           i_deliver,

  input  ifu_pkg::inst_t i_instbus_data,
  input  ifu_pkg::addr_t i_instbus_addr,

  output logic           o_ifu_vld,
  output ifu_pkg::inst_t o_ifu_inst,
  output ifu_pkg::addr_t o_ifu_inst_pc
);

  // Valid strobe toward decode
  always_ff @(posedge clk) begin
    if (rst) begin
      o_ifu_vld <= 1'b0;
    end else begin
      o_ifu_vld <= i_deliver;
    end
  end

  // Word and its echoed address are kept until the next capture
  always_ff @(posedge clk) begin
    if (i_capture) begin
      o_ifu_inst    <= i_instbus_data;
      o_ifu_inst_pc <= i_instbus_addr;
    end
  end

endmodule

// File: hw/ifu_pc_gen.sv
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_pc_gen (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_advance,
  input  logic          i_redirect,
  input  ifu_pkg::addr_t i_target,
  output ifu_pkg::addr_t o_pc
);

  ifu_pkg::addr_t pc_q;
  ifu_pkg::addr_t pc_inc;

  assign pc_inc = pc_q + ifu_pkg::addr_t'(`IFU_PC_STRIDE);

  // PC always names the next word to request
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= ifu_pkg::addr_t'(`IFU_RESET_PC);
    end else if (i_redirect) begin
      pc_q <= i_target;  // Branch miss or trap
    end else if (i_advance) begin
      pc_q <= pc_inc;
    end
  end

  assign o_pc = pc_q;

  // The fetch FSM never issues in a redirect cycle, so the target is never
  // overtaken by a sequential step
  a_no_advance_on_redirect : assert property (
    @(posedge clk) disable iff (rst)
    !(i_redirect && i_advance)
  ) else $error("ifu_pc_gen: advance and redirect in the same cycle");

endmodule

// File: hw/ifu_pkg.sv
`include "ifu_cfg.svh"

package ifu_pkg;

  typedef logic [`IFU_XLEN-1:0] addr_t;  // Instruction address
  typedef logic [`IFU_XLEN-1:0] inst_t;  // Raw instruction word

  // Fetch FSM
  typedef enum logic [1:0] {
    FS_IDLE  = 2'd0,  // Nothing outstanding, nothing held
    FS_FETCH = 2'd1,  // One bus request outstanding
    FS_HOLD  = 2'd2   // Word parked for frozen decode
  } fetch_state_t;

endpackage

// File: hw/riscv_ifu.sv
`timescale 1ns/1ps

module riscv_ifu (
  input  logic           clk,
  input  logic           rst,

  // Execute stage
  input  logic           i_alu_vld,
  input  logic           i_alu_br_miss,
  input  logic           i_alu_trap,
  input  ifu_pkg::addr_t i_alu_pc_next,

  // Decode stage
  input  logic           i_idu_freeze,
  output logic           o_ifu_vld,
  output ifu_pkg::inst_t o_ifu_inst,
  output ifu_pkg::addr_t o_ifu_inst_pc,

  // Instruction bus
  output logic           o_instbus_req,
  output ifu_pkg::addr_t o_instbus_addr,
  input  logic           i_instbus_ack,
  input  ifu_pkg::addr_t i_instbus_addr,
  input  ifu_pkg::inst_t i_instbus_data
);

  ifu_pkg::addr_t pc;
  logic           advance;
  logic           redirect;
  logic           capture;
  logic           deliver;

  ifu_pc_gen pc_gen_i (
    .clk        (clk),
    .rst        (rst),
    .i_advance  (advance),
    .i_redirect (redirect),
    .i_target   (i_alu_pc_next),
    .o_pc       (pc)
  );

  ifu_fetch_ctrl fetch_ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .i_alu_vld      (i_alu_vld),
    .i_alu_br_miss  (i_alu_br_miss),
    .i_alu_trap     (i_alu_trap),
    .i_idu_freeze   (i_idu_freeze),
    .i_instbus_ack  (i_instbus_ack),
    .i_pc           (pc),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .o_advance      (advance),
    .o_redirect     (redirect),
    .o_capture      (capture),
    .o_deliver      (deliver)
  );

  ifu_inst_buffer inst_buffer_i (
    .clk            (clk),
    .rst            (rst),
    .i_capture      (capture),
    .i_deliver      (deliver),
    .i_instbus_data (i_instbus_data),
    .i_instbus_addr (i_instbus_addr),
    .o_ifu_vld      (o_ifu_vld),
    .o_ifu_inst     (o_ifu_inst),
    .o_ifu_inst_pc  (o_ifu_inst_pc)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_riscv_ifu \
  -Mdir "$OBJ" -o tb_riscv_ifu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_riscv_ifu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// File: verilog.f
+incdir+hw
hw/ifu_pkg.sv
hw/ifu_pc_gen.sv
hw/ifu_fetch_ctrl.sv
hw/ifu_inst_buffer.sv
hw/riscv_ifu.sv
bench/instbus_model.sv
bench/tb_riscv_ifu.sv
